/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - verilog/mipsPkg.sv
  - verilog/idExIf.sv
  - verilog/fetchUnit.sv
  - verilog/pipeControl.sv
  - verilog/regFile.sv
  - verilog/executeStage.sv
  - verilog/memStage.sv
  - verilog/mipsPipeline.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tbMipsPipeline.sv

/* dv/tbIsaModel.svh */
`ifndef tbIsaModelSvh
`define tbIsaModelSvh

////////////////////
// Program image
////////////////////

localparam int progLen = 48;

// Words past progLen read as zero
logic [31:0] progMem [progLen];

// Expected register writes, program order
logic [4:0]  expReg [$];
logic [31:0] expData [$];
int          takenCount;

// Small register range, so dependencies are frequent
function automatic logic [4:0] pickReg();
    return 5'($urandom_range(7, 0));
endfunction

// Word aligned, 16 slots below 256, so loads hit and miss
function automatic logic [15:0] pickOffset();
    return 16'($urandom_range(15, 0) * 16);
endfunction

function automatic void buildProgram();
    instrU word;
    int    kind;
    for (int i = 0; i < progLen; i++) begin
        word = '0;
        kind = $urandom_range(9, 0);
        if (kind < 4) begin
            word.rType.opcode = opRType;
            word.rType.rs = pickReg();
            word.rType.rt = pickReg();
            word.rType.rd = pickReg();
            case ($urandom_range(4, 0))
                0:       word.rType.funct = fnAdd;
                1:       word.rType.funct = fnSub;
                2:       word.rType.funct = fnAnd;
                3:       word.rType.funct = fnOr;
                default: word.rType.funct = fnSlt;
            endcase
        end else if (kind < 6) begin
            // Full 16-bit range, half of them negative
            word.iType.opcode = opAddi;
            word.iType.rs = pickReg();
            word.iType.rt = pickReg();
            word.iType.imm = 16'($urandom);
        end else if (kind == 6) begin
            word.iType.opcode = opSw;
            word.iType.rt = pickReg();
            word.iType.imm = pickOffset();
        end else if (kind == 7) begin
            word.iType.opcode = opLw;
            word.iType.rt = pickReg();
            word.iType.imm = pickOffset();
        end else begin
            // Forward only, often the same register twice
            word.iType.opcode = opBeq;
            word.iType.rs = pickReg();
            word.iType.rt = ($urandom_range(1, 0) == 0) ? word.iType.rs : pickReg();
            word.iType.imm = 16'($urandom_range(3, 0));
        end
        progMem[i] = word;
    end
endfunction

////////////////////
// Reference model
////////////////////

function automatic void runReferenceModel();
    logic [31:0] regs [32];
    logic [31:0] mem [dataMemWords];
    instrU       word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] result;
    logic [31:0] addr;
    logic [4:0]  destReg;
    logic        writes;
    int          pc;
    for (int i = 0; i < 32; i++) begin
        regs[i] = 32'd0;
    end
    for (int i = 0; i < dataMemWords; i++) begin
        mem[i] = 32'd0;
    end
    takenCount = 0;
    pc = 0;
    while (pc < progLen) begin
        word = progMem[pc];
        a = regs[word.iType.rs];
        b = regs[word.iType.rt];
        imm = {{16{word.iType.imm[15]}}, word.iType.imm};
        addr = a + imm;
        destReg = word.iType.rt;
        writes = 1'b0;
        result = 32'd0;
        pc = pc + 1;
        case (word.iType.opcode)
            opRType: begin
                destReg = word.rType.rd;
                writes = 1'b1;
                case (word.rType.funct)
                    fnAdd:   result = a + b;
                    fnSub:   result = a - b;
                    fnAnd:   result = a & b;
                    fnOr:    result = a | b;
                    fnSlt:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: writes = 1'b0;
                endcase
            end
            opAddi: begin
                writes = 1'b1;
                result = a + imm;
            end
            opLw: begin
                writes = 1'b1;
                result = mem[(addr >> 2) % dataMemWords];
            end
            opSw: begin
                mem[(addr >> 2) % dataMemWords] = b;
            end
            opBeq: begin
                if (a == b) begin
                    pc = pc + int'($signed(imm));
                    takenCount++;
                end
            end
            default: ;
        endcase
        // $0 never reported
        if (writes && destReg != 5'd0) begin
            regs[destReg] = result;
            expReg.push_back(destReg);
            expData.push_back(result);
        end
    end
endfunction

`endif

/* dv/tbMipsPipeline.sv */
`default_nettype none

module tbMipsPipeline;
    import mipsPkg::*;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 8;
    localparam int idleCycles  = 40;

    logic        clk;
    logic        rst;
    logic        instrAck;
    logic [31:0] instrData;
    logic        instrReq;
    logic [31:0] instrAddr;
    logic        wbValid;
    logic [4:0]  wbReg;
    logic [31:0] wbData;

    int          errorCount;
    int          checkCount;
    int          seedInit;
    // Handshake state at the previous falling edge
    logic        prevReq;
    logic        prevAck;
    logic [31:0] prevAddr;

    `include "tbIsaModel.svh"

    // Twelve cycles per instruction, doubled, plus reset
    localparam int timeoutCycles = progLen * 12 * 2 + resetCycles;

    mipsPipeline u_mipsPipeline (
        .clk       (clk),
        .rst       (rst),
        .instrAck  (instrAck),
        .instrData (instrData),
        .instrReq  (instrReq),
        .instrAddr (instrAddr),
        .wbValid   (wbValid),
        .wbReg     (wbReg),
        .wbData    (wbData)
    );

    always #(clkPeriod / 2) clk = ~clk;

    ////////////////////
    // Fetch responder
    ////////////////////

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        if (addr[31:2] < progLen) begin
            return progMem[addr[31:2]];
        end
        return 32'd0;
    endfunction

    // Everything driven 1 unit after the rising edge
    task automatic answerFetches();
        int delay;
        forever begin
            @(posedge clk);
            #1;
            if (!rst && instrReq && !instrAck) begin
                delay = $urandom_range(3, 0);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                instrData = fetchWord(instrAddr);
                instrAck = 1'b1;
                // Hold ack until req drops
                while (instrReq) begin
                    @(posedge clk);
                    #1;
                end
                // Ack may linger after req falls
                delay = $urandom_range(3, 0);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                instrAck = 1'b0;
            end
        end
    endtask

    ////////////////////
    // Checkers
    ////////////////////

    task automatic showMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        $display("FAIL time=%0t %s expected 0x%08h got 0x%08h", $time, name, expected, actual);
        errorCount++;
    endtask

    task automatic checkWrite();
        logic [4:0]  expectReg;
        logic [31:0] expectData;
        assert (wbReg != 5'd0) else begin
            $display("Write to register 0 was reported on wbValid at time %0t", $time);
            errorCount++;
        end
        assert (expReg.size() > 0) else begin
            $display("Unexpected register write at time %0t, none was left to retire", $time);
            errorCount++;
        end
        if (expReg.size() > 0) begin
            expectReg = expReg.pop_front();
            expectData = expData.pop_front();
            checkCount++;
            assert (wbReg == expectReg) else showMismatch("wbReg", 32'(expectReg), 32'(wbReg));
            assert (wbData == expectData) else showMismatch("wbData", expectData, wbData);
        end
    endtask

    task automatic checkHandshake();
        if (rst) begin
            assert (!instrReq) else begin
                $display("instrReq was high during reset at time %0t", $time);
                errorCount++;
            end
        end else begin
            if (prevReq && instrReq) begin
                assert (instrAddr == prevAddr) else begin
                    $display("instrAddr changed while instrReq was high at time %0t", $time);
                    errorCount++;
                end
            end
            if (prevReq && !instrReq) begin
                assert (prevAck) else begin
                    $display("instrReq fell before instrAck rose at time %0t", $time);
                    errorCount++;
                end
            end
            if (!prevReq && instrReq) begin
                assert (!prevAck) else begin
                    $display("instrReq rose while instrAck was still high at time %0t", $time);
                    errorCount++;
                end
            end
        end
        prevReq = instrReq;
        prevAck = instrAck;
        prevAddr = instrAddr;
    endtask

    // Outputs settle well before the falling edge
    always @(negedge clk) begin
        checkHandshake();
        if (!rst && wbValid) begin
            checkWrite();
        end
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        instrAck = 1'b0;
        instrData = 32'd0;
        errorCount = 0;
        checkCount = 0;
        prevReq = 1'b0;
        prevAck = 1'b0;
        prevAddr = 32'd0;
        seedInit = $urandom(13);
        buildProgram();
        runReferenceModel();
        $display("Program of %0d words, %0d writes expected, %0d taken branches",
                 progLen, expReg.size(), takenCount);
        // Responder forked after seeding
        fork
            answerFetches();
        join_none
        repeat (resetCycles) @(posedge clk);
        #1;
        rst = 1'b0;
        while (expReg.size() > 0) begin
            @(negedge clk);
        end
        // Late or extra writes show up here
        repeat (idleCycles) @(posedge clk);
        $display("Summary: %0d writes checked, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(timeoutCycles * clkPeriod);
        $display("Watchdog expired after %0d cycles, the pipeline stopped retiring writes",
                 timeoutCycles);
        $display("Summary: %0d writes checked, %0d errors, %0d writes never retired",
                 checkCount, errorCount, expReg.size());
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/executeStage.sv */
`default_nettype none

module executeStage (
    input  logic        clk,
    input  logic        rst,
    idExIf.ex           idEx,
    input  logic [31:0] rsData,
    input  logic [31:0] rtData,
    output logic [4:0]  exDest,
    output logic        exRegWrite,
    output logic        branchTaken,
    output logic [31:0] branchTarget,
    output logic [31:0] aluResult,
    output logic [31:0] storeData,
    output logic        memRead,
    output logic        memWrite,
    output logic        memToReg,
    output logic        regWrite,
    output logic [4:0]  dest,
    output logic        valid
);
    import mipsPkg::*;

    // ID/EX control
    logic        validQ;
    logic        regWriteQ;
    logic        memReadQ;
    logic        memWriteQ;
    logic        memToRegQ;
    logic        branchQ;
    // ID/EX payload
    logic        aluSrcQ;
    aluOpE       aluOpQ;
    logic [4:0]  destQ;
    logic [31:0] immQ;
    logic [31:0] pcPlus4Q;
    logic [31:0] rsQ;
    logic [31:0] rtQ;
    logic [31:0] opB;

    ////////////////////
    // ID/EX register
    ////////////////////

    always_ff @(posedge clk) begin
        // Taken beq also kills whatever decode sent behind it
        if (rst || branchTaken) begin
            validQ    <= 1'b0;
            regWriteQ <= 1'b0;
            memReadQ  <= 1'b0;
            memWriteQ <= 1'b0;
            memToRegQ <= 1'b0;
            branchQ   <= 1'b0;
        end else begin
            validQ    <= idEx.valid;
            regWriteQ <= idEx.regWrite;
            memReadQ  <= idEx.memRead;
            memWriteQ <= idEx.memWrite;
            memToRegQ <= idEx.memToReg;
            branchQ   <= idEx.branch;
        end
    end

    always_ff @(posedge clk) begin
        aluSrcQ  <= idEx.aluSrc;
        aluOpQ   <= idEx.aluOp;
        destQ    <= idEx.dest;
        immQ     <= idEx.imm;
        pcPlus4Q <= idEx.pcPlus4;
        rsQ      <= rsData;
        rtQ      <= rtData;
    end

    ////////////////////
    // ALU and branch
    ////////////////////

    assign opB = aluSrcQ ? immQ : rtQ;

    always_comb begin
        case (aluOpQ)
            aluAdd:  aluResult = rsQ + opB;
            aluSub:  aluResult = rsQ - opB;
            aluAnd:  aluResult = rsQ & opB;
            aluOr:   aluResult = rsQ | opB;
            aluSlt:  aluResult = {31'd0, $signed(rsQ) < $signed(opB)};
            default: aluResult = 32'd0;
        endcase
    end

    // Word offset, so shift by two
    assign branchTarget = pcPlus4Q + {immQ[29:0], 2'b00};
    assign branchTaken  = validQ && branchQ && (rsQ == rtQ);

    // Hazard view for decode
    assign exDest     = destQ;
    assign exRegWrite = validQ && regWriteQ;

    // On to EX/MEM
    assign storeData = rtQ;
    assign memRead   = memReadQ;
    assign memWrite  = memWriteQ;
    assign memToReg  = memToRegQ;
    assign regWrite  = regWriteQ;
    assign dest      = destQ;
    assign valid     = validQ;

endmodule

`default_nettype wire

/* verilog/fetchUnit.sv */
`default_nettype none

module fetchUnit (
    input  logic           clk,
    input  logic           rst,
    input  logic           instrAck,
    input  logic [31:0]    instrData,
    input  logic           stall,
    input  logic           branchTaken,
    input  logic [31:0]    branchTarget,
    output logic           instrReq,
    output logic [31:0]    instrAddr,
    output mipsPkg::instrU ifIdInstr,
    output logic           ifIdValid,
    output logic [31:0]    ifIdPcPlus4
);
    import mipsPkg::*;

    // Address of the next word to request
    logic [31:0] fetchPc;
    logic [31:0] fetchPcNow;
    logic [31:0] addrPlus4;
    // Open fetch belongs to a squashed path
    logic        discardQ;
    logic        fetchDone;
    logic        keepWord;
    // Word fetched while ID was stalled
    logic        holdValid;
    instrU       holdInstr;
    logic [31:0] holdPcPlus4;

    assign fetchDone = instrReq && instrAck;
    // Branch in the same cycle beats the stored address
    assign fetchPcNow = branchTaken ? branchTarget : fetchPc;
    assign addrPlus4 = instrAddr + 32'd4;
    // Drop the word if its path was squashed, now or earlier
    assign keepWord = fetchDone && !discardQ && !branchTaken;

    ////////////////////
    // Handshake and PC
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            instrReq  <= 1'b0;
            instrAddr <= 32'd0;
            fetchPc   <= 32'd0;
            discardQ  <= 1'b0;
        end else begin
            // Four phase: drop req on ack, raise again only after ack falls
            if (fetchDone) begin
                instrReq <= 1'b0;
            end else if (!instrReq && !instrAck && !holdValid) begin
                instrReq  <= 1'b1;
                instrAddr <= fetchPcNow;
            end

            // Address stays put while req is high, so remember the squash
            if (fetchDone) begin
                discardQ <= 1'b0;
            end else if (instrReq && branchTaken) begin
                discardQ <= 1'b1;
            end

            if (branchTaken) begin
                fetchPc <= branchTarget;
            end else if (keepWord) begin
                fetchPc <= addrPlus4;
            end
        end
    end

    ////////////////////
    // IF/ID and holding register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            ifIdValid <= 1'b0;
            holdValid <= 1'b0;
        end else if (branchTaken) begin
            // Wrong path, flush both
            ifIdValid <= 1'b0;
            holdValid <= 1'b0;
        end else if (!stall) begin
            if (holdValid) begin
                ifIdValid <= 1'b1;
                holdValid <= 1'b0;
            end else begin
                ifIdValid <= keepWord;
            end
        end else if (keepWord) begin
            holdValid <= 1'b1;
        end
    end

    // Payload, qualified by the valid bits above
    always_ff @(posedge clk) begin
        if (stall && keepWord) begin
            holdInstr   <= instrData;
            holdPcPlus4 <= addrPlus4;
        end
        if (!stall) begin
            if (holdValid) begin
                ifIdInstr   <= holdInstr;
                ifIdPcPlus4 <= holdPcPlus4;
            end else if (keepWord) begin
                ifIdInstr   <= instrData;
                ifIdPcPlus4 <= addrPlus4;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/idExIf.sv */
`default_nettype none

// Decoded control bundle, decode to execute
interface idExIf;
    import mipsPkg::*;

    logic        valid;
    logic        regWrite;
    logic        memRead;
    logic        memWrite;
    logic        memToReg;
    // Second ALU operand from imm instead of rt
    logic        aluSrc;
    logic        branch;
    aluOpE       aluOp;
    // Already rd or rt
    logic [4:0]  dest;
    // Sign extended
    logic [31:0] imm;
    logic [31:0] pcPlus4;

    modport dec (
        output valid, regWrite, memRead, memWrite, memToReg, aluSrc, branch,
        output aluOp, dest, imm, pcPlus4
    );

    modport ex (
        input valid, regWrite, memRead, memWrite, memToReg, aluSrc, branch,
        input aluOp, dest, imm, pcPlus4
    );

endinterface

`default_nettype wire

/* verilog/memStage.sv */
`default_nettype none

module memStage (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] aluResult,
    input  logic [31:0] storeData,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic        memToReg,
    input  logic        regWrite,
    input  logic [4:0]  dest,
    input  logic        valid,
    output logic [4:0]  memDest,
    output logic        memRegWrite,
    output logic        wbValid,
    output logic [4:0]  wbReg,
    output logic [31:0] wbData
);
    import mipsPkg::*;

    localparam int addrBits = $clog2(dataMemWords);

    // EX/MEM
    logic                validM;
    logic                regWriteM;
    logic                memReadM;
    logic                memWriteM;
    logic                memToRegM;
    logic [31:0]         aluM;
    logic [31:0]         storeM;
    logic [4:0]          destM;
    logic [addrBits-1:0] wordIdx;
    logic [31:0]         loadData;
    logic [31:0] dataMem [dataMemWords];

    always_ff @(posedge clk) begin
        if (rst) begin
            validM    <= 1'b0;
            regWriteM <= 1'b0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
            memToRegM <= 1'b0;
        end else begin
            validM    <= valid;
            regWriteM <= regWrite;
            memReadM  <= memRead;
            memWriteM <= memWrite;
            memToRegM <= memToReg;
        end
    end

    always_ff @(posedge clk) begin
        aluM   <= aluResult;
        storeM <= storeData;
        destM  <= dest;
    end

    ////////////////////
    // Data memory
    ////////////////////

    // Word addressed, byte offset bits ignored
    assign wordIdx = aluM[addrBits+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < dataMemWords; i++) begin
                dataMem[i] <= 32'd0;
            end
        end else if (validM && memWriteM) begin
            dataMem[wordIdx] <= storeM;
        end
    end

    // Asynchronous read, result captured in MEM/WB
    assign loadData = memReadM ? dataMem[wordIdx] : 32'd0;

    ////////////////////
    // MEM/WB
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wbValid <= 1'b0;
        end else begin
            // Nothing reported for $0
            wbValid <= validM && regWriteM && (destM != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        wbReg  <= destM;
        wbData <= memToRegM ? loadData : aluM;
    end

    assign memDest     = destM;
    assign memRegWrite = validM && regWriteM;

endmodule

`default_nettype wire

/* verilog/mipsPipeline.sv */
`default_nettype none

module mipsPipeline (
    input  logic        clk,
    input  logic        rst,
    input  logic        instrAck,
    input  logic [31:0] instrData,
    output logic        instrReq,
    output logic [31:0] instrAddr,
    output logic        wbValid,
    output logic [4:0]  wbReg,
    output logic [31:0] wbData
);
    import mipsPkg::*;

    // IF/ID
    instrU       ifIdInstr;
    logic        ifIdValid;
    logic [31:0] ifIdPcPlus4;
    logic        stall;

    // Register file ports
    logic [4:0]  rsAddr;
    logic [4:0]  rtAddr;
    logic [31:0] rsData;
    logic [31:0] rtData;

    // Execute results
    logic [4:0]  exDest;
    logic        exRegWrite;
    logic        branchTaken;
    logic [31:0] branchTarget;
    logic [31:0] aluResult;
    logic [31:0] storeData;
    logic        memRead;
    logic        memWrite;
    logic        memToReg;
    logic        regWrite;
    logic [4:0]  dest;
    logic        exValid;

    // Memory stage hazard view
    logic [4:0]  memDest;
    logic        memRegWrite;

    idExIf idExBus ();

    ////////////////////
    // Fetch
    ////////////////////

    fetchUnit u_fetchUnit (
        .clk          (clk),
        .rst          (rst),
        .instrAck     (instrAck),
        .instrData    (instrData),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .instrReq     (instrReq),
        .instrAddr    (instrAddr),
        .ifIdInstr    (ifIdInstr),
        .ifIdValid    (ifIdValid),
        .ifIdPcPlus4  (ifIdPcPlus4)
    );

    ////////////////////
    // Decode
    ////////////////////

    pipeControl u_pipeControl (
        .ifIdInstr   (ifIdInstr),
        .ifIdValid   (ifIdValid),
        .ifIdPcPlus4 (ifIdPcPlus4),
        .exDest      (exDest),
        .exRegWrite  (exRegWrite),
        .memDest     (memDest),
        .memRegWrite (memRegWrite),
        .branchTaken (branchTaken),
        .rsAddr      (rsAddr),
        .rtAddr      (rtAddr),
        .stall       (stall),
        .idEx        (idExBus.dec)
    );

    // Written from WB, read in ID
    regFile u_regFile (
        .clk     (clk),
        .rst     (rst),
        .rsAddr  (rsAddr),
        .rtAddr  (rtAddr),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData),
        .rsData  (rsData),
        .rtData  (rtData)
    );

    ////////////////////
    // Execute, memory, writeback
    ////////////////////

    executeStage u_executeStage (
        .clk          (clk),
        .rst          (rst),
        .idEx         (idExBus.ex),
        .rsData       (rsData),
        .rtData       (rtData),
        .exDest       (exDest),
        .exRegWrite   (exRegWrite),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .aluResult    (aluResult),
        .storeData    (storeData),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memToReg     (memToReg),
        .regWrite     (regWrite),
        .dest         (dest),
        .valid        (exValid)
    );

    memStage u_memStage (
        .clk         (clk),
        .rst         (rst),
        .aluResult   (aluResult),
        .storeData   (storeData),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .memToReg    (memToReg),
        .regWrite    (regWrite),
        .dest        (dest),
        .valid       (exValid),
        .memDest     (memDest),
        .memRegWrite (memRegWrite),
        .wbValid     (wbValid),
        .wbReg       (wbReg),
        .wbData      (wbData)
    );

endmodule

`default_nettype wire

/* verilog/mipsPkg.sv */
`default_nettype none

package mipsPkg;

    ////////////////////
    // Opcodes
    ////////////////////

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opBeq   = 6'h04,
        opAddi  = 6'h08,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeE;

    // R-type funct field, bits 5:0
    typedef enum logic [5:0] {
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnOr  = 6'h25,
        fnSlt = 6'h2a
    } functE;

    ////////////////////
    // ALU
    ////////////////////

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpE;

    ////////////////////
    // Instruction word
    ////////////////////

    // Same 32 bits, register view or immediate view
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iType;
    } instrU;

    // Data memory depth in 32-bit words
    localparam int dataMemWords = 64;

endpackage

`default_nettype wire

/* verilog/pipeControl.sv */
`default_nettype none

module pipeControl (
    input  mipsPkg::instrU ifIdInstr,
    input  logic           ifIdValid,
    input  logic [31:0]    ifIdPcPlus4,
    input  logic [4:0]     exDest,
    input  logic           exRegWrite,
    input  logic [4:0]     memDest,
    input  logic           memRegWrite,
    input  logic           branchTaken,
    output logic [4:0]     rsAddr,
    output logic [4:0]     rtAddr,
    output logic           stall,
    idExIf.dec             idEx
);
    import mipsPkg::*;

    logic  decValid;
    logic  usesRt;
    logic  destIsRt;
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  memToReg;
    logic  aluSrc;
    logic  branch;
    aluOpE aluOp;
    // Decoded instruction actually enters EX
    logic  issue;

    // Pending write to src in EX or MEM, $0 never pending
    function automatic logic pendingWrite(input logic [4:0] src);
        return (src != 5'd0) &&
               ((exRegWrite && src == exDest) || (memRegWrite && src == memDest));
    endfunction

    assign rsAddr = ifIdInstr.rType.rs;
    assign rtAddr = ifIdInstr.rType.rt;

    ////////////////////
    // Decode
    ////////////////////

    always_comb begin
        decValid = 1'b0;
        usesRt   = 1'b0;
        destIsRt = 1'b1;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluSrc   = 1'b0;
        branch   = 1'b0;
        aluOp    = aluAdd;
        case (ifIdInstr.rType.opcode)
            opRType: begin
                decValid = 1'b1;
                usesRt   = 1'b1;
                destIsRt = 1'b0;
                regWrite = 1'b1;
                case (ifIdInstr.rType.funct)
                    fnAdd:   aluOp = aluAdd;
                    fnSub:   aluOp = aluSub;
                    fnAnd:   aluOp = aluAnd;
                    fnOr:    aluOp = aluOr;
                    fnSlt:   aluOp = aluSlt;
                    // All-zero word lands here too
                    default: decValid = 1'b0;
                endcase
            end
            opAddi: begin
                decValid = 1'b1;
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            opLw: begin
                decValid = 1'b1;
                regWrite = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
                aluSrc   = 1'b1;
            end
            opSw: begin
                decValid = 1'b1;
                // Store data comes from rt
                usesRt   = 1'b1;
                memWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            opBeq: begin
                decValid = 1'b1;
                usesRt   = 1'b1;
                branch   = 1'b1;
                aluOp    = aluSub;
            end
            default: decValid = 1'b0;
        endcase
    end

    ////////////////////
    // Hazards and bundle
    ////////////////////

    // No forwarding, hold in ID until the writer reaches WB
    // Every supported instruction reads rs
    assign stall = ifIdValid && decValid &&
                   (pendingWrite(rsAddr) || (usesRt && pendingWrite(rtAddr)));

    // Stalled or squashed means bubble
    assign issue = ifIdValid && decValid && !stall && !branchTaken;

    assign idEx.valid    = issue;
    assign idEx.regWrite = issue && regWrite;
    assign idEx.memRead  = issue && memRead;
    assign idEx.memWrite = issue && memWrite;
    assign idEx.memToReg = issue && memToReg;
    assign idEx.aluSrc   = aluSrc;
    assign idEx.branch   = issue && branch;
    assign idEx.aluOp    = aluOp;
    assign idEx.dest     = destIsRt ? ifIdInstr.iType.rt : ifIdInstr.rType.rd;
    assign idEx.imm      = {{16{ifIdInstr.iType.imm[15]}}, ifIdInstr.iType.imm};
    assign idEx.pcPlus4  = ifIdPcPlus4;

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  logic        wbValid,
    input  logic [4:0]  wbReg,
    input  logic [31:0] wbData,
    output logic [31:0] rsData,
    output logic [31:0] rtData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wbValid && wbReg != 5'd0) begin
            // $0 stays zero forever
            regs[wbReg] <= wbData;
        end
    end

    // Write through, so a WB in this cycle is seen by ID
    assign rsData = (wbValid && wbReg != 5'd0 && wbReg == rsAddr) ? wbData : regs[rsAddr];
    assign rtData = (wbValid && wbReg != 5'd0 && wbReg == rtAddr) ? wbData : regs[rtAddr];

endmodule

`default_nettype wire

/* vlog.f */
+incdir+dv
verilog/mipsPkg.sv
verilog/idExIf.sv
verilog/fetchUnit.sv
verilog/pipeControl.sv
verilog/regFile.sv
verilog/executeStage.sv
verilog/memStage.sv
verilog/mipsPipeline.sv
dv/tbMipsPipeline.sv
